// File: verilog/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// bus widths and memory size
`define FETCH_ADDR_W    32
`define FETCH_DATA_W    32
`define FETCH_RESET_PC  32'h0000_0000
`define IMEM_DEPTH      256

// major opcodes
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_OP_IMM  7'b0010011
`define OPC_OP      7'b0110011
`define OPC_SYSTEM  7'b1110011

// funct3 codes
`define F3_JALR   3'b000
`define F3_LB     3'b000
`define F3_LH     3'b001
`define F3_LW     3'b010
`define F3_LBU    3'b100
`define F3_LHU    3'b101
`define F3_SB     3'b000
`define F3_SH     3'b001
`define F3_SW     3'b010
`define F3_ADDI   3'b000
`define F3_SLTI   3'b010
`define F3_SLTIU  3'b011
`define F3_XORI   3'b100
`define F3_ORI    3'b110
`define F3_ANDI   3'b111
`define F3_SLLI   3'b001
`define F3_SRI    3'b101
`define F3_CSRRW  3'b001
`define F3_CSRRS  3'b010

// funct7 of the immediate shifts
`define F7_SLLI  7'b0000000
`define F7_SRLI  7'b0000000
`define F7_SRAI  7'b0100000

// system words matched as a whole
`define INST_ECALL   32'h0000_0073
`define INST_EBREAK  32'h0010_0073
`define INST_MRET    32'h3020_0073

`endif

// File: verilog/fetch_pkg.sv
`default_nettype none

`include "fetch_defines.svh"

package fetch_pkg;

	// byte address on the read channel
	typedef logic [`FETCH_ADDR_W-1:0] addr_t;

	// one instruction word
	typedef logic [`FETCH_DATA_W-1:0] word_t;

	// read response codes, only two are ever produced
	typedef enum logic [1:0] {
		OKAY   = 2'd0,
		SLVERR = 2'd2
	} resp_t;

	// fetch FSM states
	//   WAIT_ADDR    address channel pending
	//   WAIT_LOAD    data channel pending
	//   HAND_OFF     word handed to the check stage
	//   WAIT_FINISH  waiting for the pipeline to finish
	typedef enum logic [1:0] {
		WAIT_ADDR   = 2'd0,
		WAIT_LOAD   = 2'd1,
		HAND_OFF    = 2'd2,
		WAIT_FINISH = 2'd3
	} fetch_state_t;

endpackage

`default_nettype wire

// File: verilog/inst_mem.sv
`default_nettype none

`include "fetch_defines.svh"

module inst_mem (
	input  wire                    clk,
	input  wire                    rst,

	// program load port
	input  wire                    load_we_i,
	input  wire fetch_pkg::addr_t  load_addr_i,
	input  wire fetch_pkg::word_t  load_data_i,

	// read slave
	input  wire fetch_pkg::addr_t  ar_addr_i,
	input  wire                    ar_valid_i,
	output logic                   ar_ready_o,
	output fetch_pkg::word_t       r_data_o,
	output fetch_pkg::resp_t       r_resp_o,
	output logic                   r_valid_o,
	input  wire                    r_ready_i
);

	localparam int IDX_W = $clog2(`IMEM_DEPTH);

	fetch_pkg::word_t mem [`IMEM_DEPTH];

	// word indices, byte offset dropped
	logic [`FETCH_ADDR_W-3:0] ld_idx;
	logic [`FETCH_ADDR_W-3:0] rd_idx;
	logic                     ld_in_range;
	logic                     rd_in_range;
	logic                     ar_fire;

	logic             pend_q;
	fetch_pkg::word_t data_q;
	fetch_pkg::resp_t resp_q;

	assign ld_idx      = load_addr_i[`FETCH_ADDR_W-1:2];
	assign rd_idx      = ar_addr_i[`FETCH_ADDR_W-1:2];
	assign ld_in_range = (ld_idx < `IMEM_DEPTH);
	assign rd_in_range = (rd_idx < `IMEM_DEPTH);

	assign ar_ready_o = !pend_q;
	assign ar_fire    = ar_valid_i && ar_ready_o;

	assign r_valid_o = pend_q;
	assign r_data_o  = data_q;
	assign r_resp_o  = resp_q;

	always_ff @(posedge clk) begin
		if (load_we_i && ld_in_range) begin
			mem[ld_idx[IDX_W-1:0]] <= load_data_i;
		end
	end

	// one outstanding read at a time
	always_ff @(posedge clk) begin
		if (rst) begin
			pend_q <= 1'b0;
		end else if (ar_fire) begin
			pend_q <= 1'b1;
		end else if (pend_q && r_ready_i) begin
			pend_q <= 1'b0;
		end
	end

	// out of range answers slverr with zero data
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			if (rd_in_range) begin
				data_q <= mem[rd_idx[IDX_W-1:0]];
				resp_q <= fetch_pkg::OKAY;
			end else begin
				data_q <= '0;
				resp_q <= fetch_pkg::SLVERR;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/fetch_unit.sv
`default_nettype none

`include "fetch_defines.svh"

module fetch_unit (
	input  wire                    clk,
	input  wire                    rst,

	// pipeline side
	input  wire                    finish_i,
	input  wire                    csr_jmp_i,
	input  wire fetch_pkg::addr_t  csr_pc_i,
	input  wire                    jmp_flag_i,
	input  wire fetch_pkg::addr_t  jmp_target_i,
	input  wire                    branch_request_i,
	input  wire                    branch_flag_i,
	input  wire fetch_pkg::addr_t  branch_target_i,

	// read address channel
	output fetch_pkg::addr_t       ar_addr_o,
	output logic                   ar_valid_o,
	input  wire                    ar_ready_i,

	// read data channel
	input  wire fetch_pkg::word_t  r_data_i,
	input  wire fetch_pkg::resp_t  r_resp_i,
	input  wire                    r_valid_i,
	output logic                   r_ready_o,

	// toward the check stage
	output logic                   fetch_valid_o,
	output fetch_pkg::word_t       fetch_word_o,
	output fetch_pkg::addr_t       fetch_pc_o,
	output logic                   fetch_err_o
);

	localparam logic [3:0] LFSR_SEED = 4'd1;

	fetch_pkg::fetch_state_t state_q;
	fetch_pkg::fetch_state_t state_d;

	fetch_pkg::addr_t pc_q;
	fetch_pkg::addr_t pc_next;
	fetch_pkg::word_t word_q;
	logic             err_q;

	logic [3:0] lfsr_q;
	logic [3:0] delay_q;
	logic [3:0] cnt_q;
	logic       wait_done;
	logic       ar_fire;
	logic       r_fire;
	logic       state_change;

	assign wait_done    = (cnt_q == delay_q);
	assign ar_valid_o   = (state_q == fetch_pkg::WAIT_ADDR) && wait_done;
	assign r_ready_o    = (state_q == fetch_pkg::WAIT_LOAD) && wait_done;
	assign ar_fire      = ar_valid_o && ar_ready_i;
	assign r_fire       = r_ready_o && r_valid_i;
	assign state_change = (state_d != state_q);

	// pc is stable for the whole address phase
	assign ar_addr_o = pc_q;

	assign fetch_valid_o = (state_q == fetch_pkg::HAND_OFF);
	assign fetch_word_o  = word_q;
	assign fetch_pc_o    = pc_q;
	assign fetch_err_o   = err_q;

	// next pc, highest priority first
	always_comb begin
		if (csr_jmp_i) begin
			pc_next = csr_pc_i;
		end else if (jmp_flag_i) begin
			pc_next = jmp_target_i;
		end else if (branch_request_i && branch_flag_i) begin
			pc_next = branch_target_i;
		end else begin
			pc_next = pc_q + 32'd4;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			fetch_pkg::WAIT_ADDR: begin
				if (ar_fire) begin
					state_d = fetch_pkg::WAIT_LOAD;
				end
			end
			fetch_pkg::WAIT_LOAD: begin
				if (r_fire) begin
					state_d = fetch_pkg::HAND_OFF;
				end
			end
			fetch_pkg::HAND_OFF: begin
				state_d = fetch_pkg::WAIT_FINISH;
			end
			fetch_pkg::WAIT_FINISH: begin
				if (finish_i) begin
					state_d = fetch_pkg::WAIT_ADDR;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= fetch_pkg::WAIT_ADDR;
			pc_q    <= `FETCH_RESET_PC;
		end else begin
			state_q <= state_d;
			if (state_q == fetch_pkg::WAIT_FINISH && finish_i) begin
				pc_q <= pc_next;
			end
		end
	end

	// fibonacci lfsr, taps 4 and 3, free running
	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr_q <= LFSR_SEED;
		end else begin
			lfsr_q <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};
		end
	end

	// wait delay latched on entry to either bus phase
	always_ff @(posedge clk) begin
		if (rst) begin
			delay_q <= LFSR_SEED;
			cnt_q   <= 4'd0;
		end else begin
			if (state_change && (state_d == fetch_pkg::WAIT_ADDR ||
					state_d == fetch_pkg::WAIT_LOAD)) begin
				delay_q <= lfsr_q;
			end
			if (state_change) begin
				cnt_q <= 4'd0;
			end else if (!wait_done) begin
				cnt_q <= cnt_q + 4'd1;
			end
		end
	end

	// capture the returned word on the data transfer
	always_ff @(posedge clk) begin
		if (r_fire) begin
			word_q <= r_data_i;
			err_q  <= (r_resp_i != fetch_pkg::OKAY);
		end
	end

endmodule

`default_nettype wire

// File: verilog/inst_check.sv
`default_nettype none

`include "fetch_defines.svh"

module inst_check (
	input  wire                    clk,
	input  wire                    rst,

	input  wire                    fetch_valid_i,
	input  wire fetch_pkg::word_t  fetch_word_i,
	input  wire fetch_pkg::addr_t  fetch_pc_i,
	input  wire                    fetch_err_i,

	output logic                   dec_valid_o,
	output fetch_pkg::word_t       dec_inst_o,
	output fetch_pkg::addr_t       dec_pc_o,
	output logic                   dec_illegal_o
);

	logic [6:0] opcode;
	logic [2:0] f3;
	logic [6:0] f7;
	logic       legal;

	assign opcode = fetch_word_i[6:0];
	assign f3     = fetch_word_i[14:12];
	assign f7     = fetch_word_i[31:25];

	// supported rv32i subset
	always_comb begin
		legal = 1'b0;
		case (opcode)
			`OPC_LUI, `OPC_AUIPC, `OPC_JAL, `OPC_BRANCH, `OPC_OP: begin
				legal = 1'b1;
			end
			`OPC_JALR: begin
				legal = (f3 == `F3_JALR);
			end
			`OPC_LOAD: begin
				legal = (f3 == `F3_LB) || (f3 == `F3_LH) || (f3 == `F3_LW) ||
					(f3 == `F3_LBU) || (f3 == `F3_LHU);
			end
			`OPC_STORE: begin
				legal = (f3 == `F3_SB) || (f3 == `F3_SH) || (f3 == `F3_SW);
			end
			`OPC_OP_IMM: begin
				case (f3)
					`F3_ADDI, `F3_SLTI, `F3_SLTIU, `F3_XORI, `F3_ORI, `F3_ANDI: begin
						legal = 1'b1;
					end
					// shifts need a valid funct7
					`F3_SLLI: legal = (f7 == `F7_SLLI);
					`F3_SRI:  legal = (f7 == `F7_SRLI) || (f7 == `F7_SRAI);
					default:  legal = 1'b0;
				endcase
			end
			`OPC_SYSTEM: begin
				legal = (f3 == `F3_CSRRW) || (f3 == `F3_CSRRS) ||
					(fetch_word_i == `INST_ECALL) ||
					(fetch_word_i == `INST_EBREAK) ||
					(fetch_word_i == `INST_MRET);
			end
			default: begin
				legal = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			dec_valid_o <= 1'b0;
		end else begin
			dec_valid_o <= fetch_valid_i;
		end
	end

	// held until the next fetch
	always_ff @(posedge clk) begin
		if (fetch_valid_i) begin
			dec_inst_o    <= fetch_word_i;
			dec_pc_o      <= fetch_pc_i;
			dec_illegal_o <= !legal || fetch_err_i;
		end
	end

endmodule

`default_nettype wire

// File: verilog/fetch_top.sv
`default_nettype none

module fetch_top (
	input  wire                    clk,
	input  wire                    rst,

	input  wire                    load_we_i,
	input  wire fetch_pkg::addr_t  load_addr_i,
	input  wire fetch_pkg::word_t  load_data_i,

	input  wire                    finish_i,
	input  wire                    csr_jmp_i,
	input  wire fetch_pkg::addr_t  csr_pc_i,
	input  wire                    jmp_flag_i,
	input  wire fetch_pkg::addr_t  jmp_target_i,
	input  wire                    branch_request_i,
	input  wire                    branch_flag_i,
	input  wire fetch_pkg::addr_t  branch_target_i,

	output logic                   dec_valid_o,
	output fetch_pkg::word_t       dec_inst_o,
	output fetch_pkg::addr_t       dec_pc_o,
	output logic                   dec_illegal_o
);

	// read bus between fetch and memory
	fetch_pkg::addr_t ar_addr;
	logic             ar_valid;
	logic             ar_ready;
	fetch_pkg::word_t r_data;
	fetch_pkg::resp_t r_resp;
	logic             r_valid;
	logic             r_ready;

	// fetch to check stage
	logic             fetch_valid;
	fetch_pkg::word_t fetch_word;
	fetch_pkg::addr_t fetch_pc;
	logic             fetch_err;

	fetch_unit u_fetch (
		.clk              (clk),
		.rst              (rst),
		.finish_i         (finish_i),
		.csr_jmp_i        (csr_jmp_i),
		.csr_pc_i         (csr_pc_i),
		.jmp_flag_i       (jmp_flag_i),
		.jmp_target_i     (jmp_target_i),
		.branch_request_i (branch_request_i),
		.branch_flag_i    (branch_flag_i),
		.branch_target_i  (branch_target_i),
		.ar_addr_o        (ar_addr),
		.ar_valid_o       (ar_valid),
		.ar_ready_i       (ar_ready),
		.r_data_i         (r_data),
		.r_resp_i         (r_resp),
		.r_valid_i        (r_valid),
		.r_ready_o        (r_ready),
		.fetch_valid_o    (fetch_valid),
		.fetch_word_o     (fetch_word),
		.fetch_pc_o       (fetch_pc),
		.fetch_err_o      (fetch_err)
	);

	inst_mem u_mem (
		.clk         (clk),
		.rst         (rst),
		.load_we_i   (load_we_i),
		.load_addr_i (load_addr_i),
		.load_data_i (load_data_i),
		.ar_addr_i   (ar_addr),
		.ar_valid_i  (ar_valid),
		.ar_ready_o  (ar_ready),
		.r_data_o    (r_data),
		.r_resp_o    (r_resp),
		.r_valid_o   (r_valid),
		.r_ready_i   (r_ready)
	);

	inst_check u_check (
		.clk           (clk),
		.rst           (rst),
		.fetch_valid_i (fetch_valid),
		.fetch_word_i  (fetch_word),
		.fetch_pc_i    (fetch_pc),
		.fetch_err_i   (fetch_err),
		.dec_valid_o   (dec_valid_o),
		.dec_inst_o    (dec_inst_o),
		.dec_pc_o      (dec_pc_o),
		.dec_illegal_o (dec_illegal_o)
	);

endmodule

`default_nettype wire

// File: testbench/fetch_tb.sv
`default_nettype none

module fetch_tb;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 4;
	localparam int PAT_WORDS    = 1024;
	localparam int STEP_WORDS   = 7;
	localparam int STEP_CYCLES  = 64;
	localparam int LONG_STALL   = 24;

	logic             clk;
	logic             rst;
	logic             load_we;
	fetch_pkg::addr_t load_addr;
	fetch_pkg::word_t load_data;
	logic             finish;
	logic             csr_jmp;
	fetch_pkg::addr_t csr_pc;
	logic             jmp_flag;
	fetch_pkg::addr_t jmp_target;
	logic             branch_request;
	logic             branch_flag;
	fetch_pkg::addr_t branch_target;

	logic             dec_valid;
	fetch_pkg::word_t dec_inst;
	fetch_pkg::addr_t dec_pc;
	logic             dec_illegal;

	// load records first, then step records
	logic [31:0] pat [PAT_WORDS];
	int          errors;
	int          load_count;
	int          step_count;
	logic        pat_ready;

	fetch_top uut (
		.clk              (clk),
		.rst              (rst),
		.load_we_i        (load_we),
		.load_addr_i      (load_addr),
		.load_data_i      (load_data),
		.finish_i         (finish),
		.csr_jmp_i        (csr_jmp),
		.csr_pc_i         (csr_pc),
		.jmp_flag_i       (jmp_flag),
		.jmp_target_i     (jmp_target),
		.branch_request_i (branch_request),
		.branch_flag_i    (branch_flag),
		.branch_target_i  (branch_target),
		.dec_valid_o      (dec_valid),
		.dec_inst_o       (dec_inst),
		.dec_pc_o         (dec_pc),
		.dec_illegal_o    (dec_illegal)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	task automatic check_addr(input string name, input fetch_pkg::addr_t got,
			input fetch_pkg::addr_t exp);
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input fetch_pkg::word_t got,
			input fetch_pkg::word_t exp);
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic drive_idle();
		finish         = 1'b0;
		csr_jmp        = 1'b0;
		csr_pc         = '0;
		jmp_flag       = 1'b0;
		jmp_target     = '0;
		branch_request = 1'b0;
		branch_flag    = 1'b0;
		branch_target  = '0;
	endtask

	// program image goes in while the core is held in reset
	task automatic load_image();
		for (int i = 0; i < load_count; i++) begin
			load_we   = 1'b1;
			load_addr = pat[1 + 2 * i];
			load_data = pat[2 + 2 * i];
			@(negedge clk);
		end
		load_we = 1'b0;
	endtask

	task automatic wait_dec_valid();
		while (dec_valid !== 1'b1) begin
			@(negedge clk);
		end
	endtask

	// finish_i low, so nothing may move
	task automatic hold_outputs(input int cycles);
		fetch_pkg::addr_t pc_held;
		fetch_pkg::word_t inst_held;
		logic             ill_held;
		pc_held   = dec_pc;
		inst_held = dec_inst;
		ill_held  = dec_illegal;
		repeat (cycles) begin
			@(negedge clk);
			check_flag("dec_valid_o", dec_valid, 1'b0);
			check_addr("dec_pc_o", dec_pc, pc_held);
			check_word("dec_inst_o", dec_inst, inst_held);
			check_flag("dec_illegal_o", dec_illegal, ill_held);
		end
	endtask

	// one cycle finish with the redirect for the next pc
	task automatic issue_finish(input logic [3:0] cmd, input fetch_pkg::addr_t csr_tgt,
			input fetch_pkg::addr_t jmp_tgt, input fetch_pkg::addr_t br_tgt);
		finish         = 1'b1;
		csr_jmp        = cmd[0];
		jmp_flag       = cmd[1];
		branch_request = cmd[2];
		branch_flag    = cmd[3];
		csr_pc         = csr_tgt;
		jmp_target     = jmp_tgt;
		branch_target  = br_tgt;
		@(negedge clk);
		drive_idle();
	endtask

	initial begin
		int base;
		int delay;
		errors    = 0;
		pat_ready = 1'b0;
		void'($urandom(32'he9c1));
		rst       = 1'b1;
		load_we   = 1'b0;
		load_addr = '0;
		load_data = '0;
		drive_idle();
		$readmemh("testbench/fetch_patterns.txt", pat);
		if ($isunknown(pat[0])) begin
			errors++;
			$display("pattern file could not be read or has no load count");
		end else begin
			load_count = pat[0];
			step_count = pat[2 * load_count + 1];
			pat_ready  = 1'b1;
			@(negedge clk);
			load_image();
			repeat (RESET_CYCLES) @(negedge clk);
			rst = 1'b0;
			for (int s = 0; s < step_count; s++) begin
				base = 2 * load_count + 2 + s * STEP_WORDS;
				wait_dec_valid();
				check_addr("dec_pc_o", dec_pc, pat[base + 4]);
				check_word("dec_inst_o", dec_inst, pat[base + 5]);
				check_flag("dec_illegal_o", dec_illegal, pat[base + 6][0]);
				delay = int'($urandom % 6);
				if (pat[base][4]) begin
					delay += LONG_STALL;
				end
				hold_outputs(delay);
				issue_finish(pat[base][3:0], pat[base + 1], pat[base + 2], pat[base + 3]);
			end
		end
		$display("steps run: %0d, errors: %0d", step_count, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// budget per step covers the longest stall plus both bus waits
	initial begin
		fetch_pkg::fetch_state_t st;
		wait (pat_ready);
		#((load_count + RESET_CYCLES + step_count * STEP_CYCLES) * CLK_PERIOD);
		st = uut.u_fetch.state_q;
		$display("timeout: fetch did not complete in time, fetch FSM in state %s", st.name());
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/inst_mem.sv
verilog/fetch_unit.sv
verilog/inst_check.sv
verilog/fetch_top.sv
testbench/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_front_end

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fetch_pkg.sv
      - verilog/inst_mem.sv
      - verilog/fetch_unit.sv
      - verilog/inst_check.sv
      - verilog/fetch_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/fetch_tb.sv

// File: testbench/fetch_patterns.txt
// load count, then one record per load: address word
// step count, then per step: cmd csr_pc jmp_target branch_target exp_pc exp_word exp_illegal
17
00000000 00100093
00000004 12345137
00000008 00000197
0000000C 00208233
00000010 0000A283
00000014 0050A223
00000018 00309313
0000001C 4020D393
00000020 02009313
00000024 0000007F
00000028 0000B283
0000002C 00000063
00000030 00000073
00000034 00100073
00000038 30200073
0000003C 30009073
00000040 342020F3
00000044 10500073
00000048 000000EF
0000004C 00008067
00000050 00009067
00000054 0050B223
000003FC 00500093
// cmd bits: 0 csr_jmp, 1 jmp_flag, 2 branch_request, 3 branch_flag, 4 long stall
1B
00 00000000 00000000 00000000 00000000 00100093 0
00 00000000 00000000 00000000 00000004 12345137 0
00 00000000 00000000 00000000 00000008 00000197 0
10 00000000 00000000 00000000 0000000C 00208233 0
00 00000000 00000000 00000000 00000010 0000A283 0
00 00000000 00000000 00000000 00000014 0050A223 0
00 00000000 00000000 00000000 00000018 00309313 0
00 00000000 00000000 00000000 0000001C 4020D393 0
00 00000000 00000000 00000000 00000020 02009313 1
00 00000000 00000000 00000000 00000024 0000007F 1
02 00000000 00000048 00000000 00000028 0000B283 1
01 00000030 00000000 00000000 00000048 000000EF 0
00 00000000 00000000 00000000 00000030 00000073 0
00 00000000 00000000 00000000 00000034 00100073 0
0C 00000000 00000000 0000002C 00000038 30200073 0
04 00000000 00000000 00000000 0000002C 00000063 0
0F 0000003C 00000000 00000004 00000030 00000073 0
0E 00000000 00000040 00000000 0000003C 30009073 0
00 00000000 00000000 00000000 00000040 342020F3 0
02 00000000 0000004C 00000000 00000044 10500073 1
00 00000000 00000000 00000000 0000004C 00008067 0
00 00000000 00000000 00000000 00000050 00009067 1
1C 00000000 00000000 00000400 00000054 0050B223 1
00 00000000 00000000 00000000 00000400 00000000 1
01 000003FC 00000000 00000000 00000404 00000000 1
0C 00000000 00000000 00000000 000003FC 00500093 0
00 00000000 00000000 00000000 00000000 00100093 0
